/* Makefile */
# Verilator build and run for the tile fabric testbench
VERILATOR ?= verilator
TOP       ?= tb_mp64_tile_fabric
RTL_TOP   ?= mp64_tile_fabric
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Finished with no errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# Status comes from grep, so a failing run fails the target
run: build
	@out="$$($(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

/* mp64_pkg.sv */
// Tile fabric package with shared constants and the request payload types
package mp64_pkg;

    // ================================================
    // Fabric sizing
    // ================================================

    // Cores sharing the tile fabric, one slot each
    localparam int NUM_CORES    = 4;
    // Enough bits to name any core
    localparam int CORE_ID_BITS = 2;

    // Byte address as issued by a core
    localparam int TILE_ADDR_W  = 32;
    // One tile word
    localparam int TILE_DATA_W  = 64;

    // ================================================
    // Internal tile memory
    // ================================================

    // Addresses below this go to the BRAM, everything else goes external
    localparam int BRAM_BYTES     = 16384;
    // log2(BRAM_BYTES / 8), word index into the BRAM
    localparam int BRAM_WORD_BITS = 11;

    // ================================================
    // Request payloads
    // ================================================

    // Internal path: word index only, byte offset is dropped
    typedef struct packed {
        logic [BRAM_WORD_BITS-1:0] word;
        logic                      wen;
        logic [TILE_DATA_W-1:0]    wdata;
    } tile_int_req_t;

    // External path keeps the full byte address
    typedef struct packed {
        logic [TILE_ADDR_W-1:0]    addr;
        logic                      wen;
        logic [TILE_DATA_W-1:0]    wdata;
    } tile_ext_req_t;

endpackage

/* mp64_tile_arbiter.sv */
// Round-robin arbiter granting one tile slot at a time to a shared memory port
`timescale 1ns/1ns

module mp64_tile_arbiter #(
    parameter type payload_t = mp64_pkg::tile_int_req_t
) (
    input  logic                                   sys_clk,
    input  logic                                   sys_rst_n,

    // Slot side
    input  logic     [mp64_pkg::NUM_CORES-1:0]     slot_req,
    input  payload_t [mp64_pkg::NUM_CORES-1:0]     slot_payload,
    output logic     [mp64_pkg::NUM_CORES-1:0]     grant_ack,
    output logic     [mp64_pkg::TILE_DATA_W-1:0]   grant_rdata,

    // Shared port side
    output logic                                   port_req,
    output payload_t                               port_payload,
    input  logic                                   port_ack,
    input  logic     [mp64_pkg::TILE_DATA_W-1:0]   port_rdata
);

    // Arbiter state
    logic [mp64_pkg::CORE_ID_BITS-1:0] grant;
    logic [mp64_pkg::CORE_ID_BITS-1:0] last_grant;
    logic                              busy;

    // Scan result
    logic [mp64_pkg::CORE_ID_BITS-1:0] next_grant;
    logic                              any_req;

    // ================================================
    // Round-robin scan
    // ================================================
    // Start one past last_grant and wrap, so last_grant itself comes last.
    // Scanning the offsets downward lets the nearest pending slot win.
    always_comb begin
        int idx;
        next_grant = last_grant;
        any_req    = 1'b0;
        for (int i = mp64_pkg::NUM_CORES; i >= 1; i--) begin
            idx = (int'(last_grant) + i) % mp64_pkg::NUM_CORES;
            if (slot_req[idx]) begin
                next_grant = idx[mp64_pkg::CORE_ID_BITS-1:0];
                any_req    = 1'b1;
            end
        end
    end

    // ================================================
    // Grant register
    // ================================================
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            grant      <= '0;
            last_grant <= '0;
            busy       <= 1'b0;
        end else begin
            if (busy) begin
                // Hold the grant until the port finishes
                if (port_ack) begin
                    busy       <= 1'b0;
                    last_grant <= grant;
                end
            end else if (any_req) begin
                grant <= next_grant;
                busy  <= 1'b1;
            end
        end
    end

    // Request is a registered level, high from the cycle after the grant
    assign port_req     = busy;
    assign port_payload = slot_payload[grant];

    // Everyone sees the data, only the winner sees the ack
    assign grant_rdata = port_rdata;

    genvar s;
    generate
        for (s = 0; s < mp64_pkg::NUM_CORES; s++) begin : g_ack
            assign grant_ack[s] = port_ack && busy && (int'(grant) == s);
        end
    endgenerate

endmodule

/* mp64_tile_bram.sv */
// Shared on-chip tile memory answering each request with a one-cycle acknowledge
`timescale 1ns/1ns

module mp64_tile_bram (
    input  logic                               sys_clk,
    input  logic                               sys_rst_n,
    input  logic                               port_req,
    input  mp64_pkg::tile_int_req_t            port_payload,
    output logic                               port_ack,
    output logic [mp64_pkg::TILE_DATA_W-1:0]   port_rdata
);

    // 2048 words of 64 bits
    logic [mp64_pkg::TILE_DATA_W-1:0] mem [2**mp64_pkg::BRAM_WORD_BITS];

    // First cycle of a request; the ack cycle still sees port_req high
    logic access;

    assign access = port_req && !port_ack;

    // Ack pulse, never two in a row
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            port_ack <= 1'b0;
        end else begin
            port_ack <= access;
        end
    end

    // ================================================
    // Array access
    // ================================================
    // Read or write happens once per request
    always_ff @(posedge sys_clk) begin
        if (access) begin
            if (port_payload.wen) begin
                mem[port_payload.word] <= port_payload.wdata;
            end else begin
                port_rdata <= mem[port_payload.word];
            end
        end
    end

endmodule

/* mp64_tile_fabric.sv */
// Tile memory fabric top joining per-core slots, both arbiters and the tile BRAM
`timescale 1ns/1ns

module mp64_tile_fabric (
    input  logic                                                      sys_clk,
    input  logic                                                      sys_rst_n,

    // Core side, indexed by core
    input  logic [mp64_pkg::NUM_CORES-1:0]                            core_req,
    input  logic [mp64_pkg::NUM_CORES-1:0][mp64_pkg::TILE_ADDR_W-1:0] core_addr,
    input  logic [mp64_pkg::NUM_CORES-1:0]                            core_wen,
    input  logic [mp64_pkg::NUM_CORES-1:0][mp64_pkg::TILE_DATA_W-1:0] core_wdata,
    output logic [mp64_pkg::NUM_CORES-1:0][mp64_pkg::TILE_DATA_W-1:0] core_rdata,
    output logic [mp64_pkg::NUM_CORES-1:0]                            core_ack,
    output logic [mp64_pkg::NUM_CORES-1:0]                            core_busy,

    // External memory port
    output logic                                                      ext_req,
    output logic [mp64_pkg::TILE_ADDR_W-1:0]                          ext_addr,
    output logic                                                      ext_wen,
    output logic [mp64_pkg::TILE_DATA_W-1:0]                          ext_wdata,
    input  logic [mp64_pkg::TILE_DATA_W-1:0]                          ext_rdata,
    input  logic                                                      ext_ack
);

    // ================================================
    // Slot to arbiter wiring
    // ================================================

    // Internal path
    logic                    [mp64_pkg::NUM_CORES-1:0] slot_int_req;
    mp64_pkg::tile_int_req_t [mp64_pkg::NUM_CORES-1:0] slot_int_payload;
    logic                    [mp64_pkg::NUM_CORES-1:0] slot_int_ack;
    logic [mp64_pkg::TILE_DATA_W-1:0]                  int_rdata;

    // External path
    logic                    [mp64_pkg::NUM_CORES-1:0] slot_ext_req;
    mp64_pkg::tile_ext_req_t [mp64_pkg::NUM_CORES-1:0] slot_ext_payload;
    logic                    [mp64_pkg::NUM_CORES-1:0] slot_ext_ack;
    logic [mp64_pkg::TILE_DATA_W-1:0]                  ext_slot_rdata;

    // BRAM port
    logic                             bram_req;
    mp64_pkg::tile_int_req_t          bram_payload;
    logic                             bram_ack;
    logic [mp64_pkg::TILE_DATA_W-1:0] bram_rdata;

    // Granted external request before it is split onto the pins
    mp64_pkg::tile_ext_req_t ext_port_payload;

    // One slot per core
    genvar c;
    generate
        for (c = 0; c < mp64_pkg::NUM_CORES; c++) begin : g_slot
            mp64_tile_slot u_slot (
                .sys_clk     (sys_clk),
                .sys_rst_n   (sys_rst_n),
                .core_req    (core_req[c]),
                .core_addr   (core_addr[c]),
                .core_wen    (core_wen[c]),
                .core_wdata  (core_wdata[c]),
                .core_rdata  (core_rdata[c]),
                .core_ack    (core_ack[c]),
                .core_busy   (core_busy[c]),
                .int_req     (slot_int_req[c]),
                .int_payload (slot_int_payload[c]),
                .int_ack     (slot_int_ack[c]),
                .int_rdata   (int_rdata),
                .ext_req     (slot_ext_req[c]),
                .ext_payload (slot_ext_payload[c]),
                .ext_ack     (slot_ext_ack[c]),
                .ext_rdata   (ext_slot_rdata)
            );
        end
    endgenerate

    // ================================================
    // Internal path, arbiter into BRAM
    // ================================================
    mp64_tile_arbiter #(
        .payload_t (mp64_pkg::tile_int_req_t)
    ) u_int_arb (
        .sys_clk      (sys_clk),
        .sys_rst_n    (sys_rst_n),
        .slot_req     (slot_int_req),
        .slot_payload (slot_int_payload),
        .grant_ack    (slot_int_ack),
        .grant_rdata  (int_rdata),
        .port_req     (bram_req),
        .port_payload (bram_payload),
        .port_ack     (bram_ack),
        .port_rdata   (bram_rdata)
    );

    mp64_tile_bram u_bram (
        .sys_clk      (sys_clk),
        .sys_rst_n    (sys_rst_n),
        .port_req     (bram_req),
        .port_payload (bram_payload),
        .port_ack     (bram_ack),
        .port_rdata   (bram_rdata)
    );

    // ================================================
    // External path, arbiter onto the ext port
    // ================================================
    mp64_tile_arbiter #(
        .payload_t (mp64_pkg::tile_ext_req_t)
    ) u_ext_arb (
        .sys_clk      (sys_clk),
        .sys_rst_n    (sys_rst_n),
        .slot_req     (slot_ext_req),
        .slot_payload (slot_ext_payload),
        .grant_ack    (slot_ext_ack),
        .grant_rdata  (ext_slot_rdata),
        .port_req     (ext_req),
        .port_payload (ext_port_payload),
        .port_ack     (ext_ack),
        .port_rdata   (ext_rdata)
    );

    // Address goes out as the core issued it
    assign ext_addr  = ext_port_payload.addr;
    assign ext_wen   = ext_port_payload.wen;
    assign ext_wdata = ext_port_payload.wdata;

endmodule

/* mp64_tile_slot.sv */
// Per-core tile slot that holds one access, routes it by address and returns the result
`timescale 1ns/1ns

module mp64_tile_slot (
    input  logic                               sys_clk,
    input  logic                               sys_rst_n,

    // Core side
    input  logic                               core_req,
    input  logic [mp64_pkg::TILE_ADDR_W-1:0]   core_addr,
    input  logic                               core_wen,
    input  logic [mp64_pkg::TILE_DATA_W-1:0]   core_wdata,
    output logic [mp64_pkg::TILE_DATA_W-1:0]   core_rdata,
    output logic                               core_ack,
    output logic                               core_busy,

    // Internal path arbiter
    output logic                               int_req,
    output mp64_pkg::tile_int_req_t            int_payload,
    input  logic                               int_ack,
    input  logic [mp64_pkg::TILE_DATA_W-1:0]   int_rdata,

    // External path arbiter
    output logic                               ext_req,
    output mp64_pkg::tile_ext_req_t            ext_payload,
    input  logic                               ext_ack,
    input  logic [mp64_pkg::TILE_DATA_W-1:0]   ext_rdata
);

    // Latched request, held stable while pending
    logic [mp64_pkg::TILE_ADDR_W-1:0] addr_q;
    logic                             wen_q;
    logic [mp64_pkg::TILE_DATA_W-1:0] wdata_q;

    // Path chosen once at accept time
    logic path_ext_q;
    logic addr_is_ext;
    logic accept;

    // Completion from whichever path this slot is waiting on
    logic                             path_ack;
    logic [mp64_pkg::TILE_DATA_W-1:0] path_rdata;

    // Anything from the top of the BRAM upward is external
    assign addr_is_ext = (core_addr >= mp64_pkg::TILE_ADDR_W'(mp64_pkg::BRAM_BYTES));

    // A pulse while busy is simply dropped
    assign accept = core_req && !core_busy;

    assign path_ack   = path_ext_q ? ext_ack   : int_ack;
    assign path_rdata = path_ext_q ? ext_rdata : int_rdata;

    // Pending level follows busy, only one line ever high
    assign int_req = core_busy && !path_ext_q;
    assign ext_req = core_busy &&  path_ext_q;

    // Payloads built from the latched fields
    assign int_payload = '{word:  addr_q[mp64_pkg::BRAM_WORD_BITS+2:3],
                           wen:   wen_q,
                           wdata: wdata_q};
    assign ext_payload = '{addr:  addr_q,
                           wen:   wen_q,
                           wdata: wdata_q};

    // ================================================
    // Control
    // ================================================
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            core_busy  <= 1'b0;
            core_ack   <= 1'b0;
            path_ext_q <= 1'b0;
        end else begin
            // Ack is a single-cycle pulse
            core_ack <= 1'b0;
            if (accept) begin
                core_busy  <= 1'b1;
                path_ext_q <= addr_is_ext;
            end else if (core_busy && path_ack) begin
                // Busy drops in the same cycle the ack shows
                core_busy <= 1'b0;
                core_ack  <= 1'b1;
            end
        end
    end

    // Request capture
    always_ff @(posedge sys_clk) begin
        if (accept) begin
            addr_q  <= core_addr;
            wen_q   <= core_wen;
            wdata_q <= core_wdata;
        end
    end

    // Read data held until the next read completes, writes leave it alone
    always_ff @(posedge sys_clk) begin
        if (core_busy && path_ack && !wen_q) begin
            core_rdata <= path_rdata;
        end
    end

endmodule

/* sim.f */
mp64_pkg.sv
mp64_tile_slot.sv
mp64_tile_arbiter.sv
mp64_tile_bram.sv
mp64_tile_fabric.sv
tb_ext_mem_model.sv
tb_mp64_tile_fabric.sv

/* tb_ext_mem_model.sv */
// Behavioral external memory that answers each tile request a fixed number of cycles later
`timescale 1ns/1ns

module tb_ext_mem_model #(
    parameter int ACK_DELAY = 3
) (
    input  logic                               sys_clk,
    input  logic                               sys_rst_n,
    input  logic                               ext_req,
    input  logic [mp64_pkg::TILE_ADDR_W-1:0]   ext_addr,
    input  logic                               ext_wen,
    input  logic [mp64_pkg::TILE_DATA_W-1:0]   ext_wdata,
    output logic [mp64_pkg::TILE_DATA_W-1:0]   ext_rdata,
    output logic                               ext_ack
);

    // Words kept by byte address, only where written
    logic [mp64_pkg::TILE_DATA_W-1:0] store [logic [mp64_pkg::TILE_ADDR_W-1:0]];
    // Cycles seen since ext_req rose
    int                               wait_cnt;

    always @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            ext_ack   <= 1'b0;
            ext_rdata <= '0;
            wait_cnt  <= 0;
        end else begin
            ext_ack <= 1'b0;
            // ext_req is still high in the ack cycle, no restart there
            if (ext_req && !ext_ack) begin
                if (wait_cnt == ACK_DELAY - 1) begin
                    ext_ack  <= 1'b1;
                    wait_cnt <= 0;
                    if (ext_wen) begin
                        store[ext_addr] = ext_wdata;
                    end else if (store.exists(ext_addr)) begin
                        ext_rdata <= store[ext_addr];
                    end else begin
                        // Unwritten words read back a pattern of their address
                        ext_rdata <= {~ext_addr, ext_addr};
                    end
                end else begin
                    wait_cnt <= wait_cnt + 1;
                end
            end
        end
    end

endmodule

/* tb_mp64_tile_fabric.sv */
// Testbench for the tile memory fabric covering sharing, routing and round-robin order
`timescale 1ns/1ns

module tb_mp64_tile_fabric;

    localparam int N              = mp64_pkg::NUM_CORES;
    localparam int AW             = mp64_pkg::TILE_ADDR_W;
    localparam int DW             = mp64_pkg::TILE_DATA_W;
    localparam int DRIVE_DELAY    = 1;
    localparam int ACK_LIMIT      = 40;
    // Reset plus six tests need a few hundred cycles, the rest is margin
    localparam int TIMEOUT_CYCLES = 2000;

    logic                 sys_clk;
    logic                 sys_rst_n;
    logic [N-1:0]         core_req;
    logic [N-1:0][AW-1:0] core_addr;
    logic [N-1:0]         core_wen;
    logic [N-1:0][DW-1:0] core_wdata;
    logic [N-1:0][DW-1:0] core_rdata;
    logic [N-1:0]         core_ack;
    logic [N-1:0]         core_busy;
    logic                 ext_req;
    logic [AW-1:0]        ext_addr;
    logic                 ext_wen;
    logic [DW-1:0]        ext_wdata;
    logic [DW-1:0]        ext_rdata;
    logic                 ext_ack;

    int          errors;
    int          test_errors;
    int          tests_run;
    int          tests_failed;
    int          cycle_count;
    logic [31:0] lcg_state;
    logic [AW-1:0] exp_ext_addr;
    logic          exp_ext_wen;
    logic [DW-1:0] exp_ext_wdata;
    int          ack_order[$];
    // Data each core wrote in the contention test
    logic [DW-1:0] core_data [N];

    mp64_tile_fabric u_dut (.*);
    tb_ext_mem_model u_ext_mem (.*);

    initial begin
        sys_clk = 1'b0;
        forever #50 sys_clk = ~sys_clk;
    end

    // Watchdog
    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge sys_clk);
            cycle_count++;
        end
        $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Finished with errors");
        $finish;
    end

    // ==================================================
    // Helpers
    // ==================================================
    function automatic logic [DW-1:0] next_data();
        logic [31:0] hi;
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        hi        = lcg_state;
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return {hi, lcg_state};
    endfunction

    task automatic report_error(input string msg);
        $display("Error at %0t ns: %s", $time, msg);
        errors++;
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors == test_errors) begin
            $display("Test %0d %s: pass", tests_run, name);
        end else begin
            $display("Test %0d %s: fail", tests_run, name);
            tests_failed++;
        end
        test_errors = errors;
    endtask

    // Counts cycles until core_ack, drops the request after its first edge
    task automatic wait_ack(input int core, inout int cycles);
        bit got;
        got = 1'b0;
        while (!got && cycles < ACK_LIMIT) begin
            @(posedge sys_clk);
            #DRIVE_DELAY;
            cycles++;
            core_req[core] = 1'b0;
            got = core_ack[core];
        end
        if (!got) begin
            $display("Core %0d got no acknowledge within %0d cycles", core, ACK_LIMIT);
            errors++;
        end
    endtask

    task automatic run_access(input int core, input logic [AW-1:0] addr, input logic wen,
                              input logic [DW-1:0] wdata, output logic [DW-1:0] rdata,
                              output int cycles);
        core_addr[core]  = addr;
        core_wen[core]   = wen;
        core_wdata[core] = wdata;
        core_req[core]   = 1'b1;
        exp_ext_addr     = addr;
        exp_ext_wen      = wen;
        exp_ext_wdata    = wdata;
        cycles = 0;
        wait_ack(core, cycles);
        rdata = core_rdata[core];
    endtask

    // All cores requested together; acks must follow the round-robin scan
    task automatic collect_acks();
        int cycles;
        cycles = 0;
        ack_order.delete();
        while (ack_order.size() < N && cycles < ACK_LIMIT) begin
            @(posedge sys_clk);
            #DRIVE_DELAY;
            cycles++;
            core_req = '0;
            for (int c = 0; c < N; c++) begin
                if (core_ack[c]) ack_order.push_back(c);
            end
        end
        if (ack_order.size() < N) begin
            $display("Only %0d of %0d cores were acknowledged", ack_order.size(), N);
            errors++;
        end
        // Scan starts one past last_grant, which is core 0 here
        for (int k = 0; k < ack_order.size(); k++) begin
            assert (ack_order[k] == (k + 1) % N)
                else report_error($sformatf("ack %0d from core %0d", k, ack_order[k]));
        end
    endtask

    // External port only carries external addresses, with the request exactly as issued
    always @(posedge sys_clk) begin
        if (sys_rst_n && ext_req) begin
            assert (exp_ext_addr >= 32'(mp64_pkg::BRAM_BYTES))
                else report_error($sformatf("internal address %h on ext port", ext_addr));
            assert (ext_addr == exp_ext_addr)
                else report_error($sformatf("ext_addr %h, expected %h", ext_addr, exp_ext_addr));
            assert (ext_wen == exp_ext_wen && ext_wdata == exp_ext_wdata)
                else report_error($sformatf("ext_wen %b ext_wdata %h, expected %b %h",
                                            ext_wen, ext_wdata, exp_ext_wen, exp_ext_wdata));
        end
    end

    // ==================================================
    // Tests
    // ==================================================
    initial begin
        logic [DW-1:0] rd;
        logic [DW-1:0] wd;
        logic [DW-1:0] ext_wd;
        int            cyc;
        errors = 0;
        test_errors = 0;
        tests_run = 0;
        tests_failed = 0;
        lcg_state = 32'hf149_18c6;
        exp_ext_addr = '0;
        exp_ext_wen = 1'b0;
        exp_ext_wdata = '0;
        sys_rst_n = 1'b0;
        core_req = '0;
        core_addr = '0;
        core_wen = '0;
        core_wdata = '0;
        repeat (16) @(posedge sys_clk);
        #DRIVE_DELAY;
        sys_rst_n = 1'b1;

        assert (core_busy == '0 && core_ack == '0 && !ext_req)
            else report_error("control outputs not idle after reset");
        end_test("reset state");

        // Must run while last_grant is still at its reset value
        for (int c = 0; c < N; c++) begin
            core_data[c]  = next_data();
            core_addr[c]  = 32'h100 + 32'(c * 8);
            core_wen[c]   = 1'b1;
            core_wdata[c] = core_data[c];
        end
        core_req = '1;
        collect_acks();
        core_wen = '0;
        core_req = '1;
        collect_acks();
        for (int c = 0; c < N; c++) begin
            assert (core_rdata[c] == core_data[c])
                else report_error($sformatf("core %0d read %h", c, core_rdata[c]));
        end
        end_test("contention order");

        wd = next_data();
        run_access(1, 32'h200, 1'b1, wd, rd, cyc);
        assert (cyc == 4) else report_error($sformatf("write took %0d cycles", cyc));
        assert (rd == core_data[1]) else report_error("write changed core_rdata");
        run_access(1, 32'h200, 1'b0, '0, rd, cyc);
        assert (cyc == 4 && rd == wd)
            else report_error($sformatf("read %h in %0d cycles, expected %h", rd, cyc, wd));
        end_test("single core write and read");

        ext_wd = next_data();
        run_access(0, 32'h300, 1'b1, ext_wd, rd, cyc);
        run_access(3, 32'h300, 1'b0, '0, rd, cyc);
        assert (rd == ext_wd) else report_error($sformatf("core 3 read %h", rd));
        end_test("shared memory");

        // Same word index as 0x200 inside the BRAM
        ext_wd = next_data();
        run_access(2, 32'(mp64_pkg::BRAM_BYTES) + 32'h200, 1'b1, ext_wd, rd, cyc);
        run_access(2, 32'(mp64_pkg::BRAM_BYTES) + 32'h200, 1'b0, '0, rd, cyc);
        assert (rd == ext_wd) else report_error($sformatf("external read %h", rd));
        run_access(1, 32'h200, 1'b0, '0, rd, cyc);
        assert (rd == wd) else report_error("external write reached the BRAM");
        end_test("external routing");

        // Read accepted, then a write pulse while busy that must vanish
        core_addr[2] = 32'h110;
        core_wen[2]  = 1'b0;
        core_req[2]  = 1'b1;
        @(posedge sys_clk);
        #DRIVE_DELAY;
        core_wen[2]   = 1'b1;
        core_wdata[2] = next_data();
        cyc = 1;
        wait_ack(2, cyc);
        assert (core_rdata[2] == core_data[2]) else report_error("busy read returned bad data");
        repeat (6) begin
            @(posedge sys_clk);
            #DRIVE_DELAY;
            assert (!core_ack[2] && !core_busy[2]) else report_error("extra ack or busy");
        end
        run_access(2, 32'h110, 1'b0, '0, rd, cyc);
        assert (rd == core_data[2]) else report_error("pulse while busy was executed");
        end_test("request while busy");

        $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule
